/* Makefile */
# Verilator build and run of the Baugh-Wooley multiplier testbench
# any variable below can be overridden, for example: make test SEED=12345678

TOP       ?= bw_mult_tb
SEED      ?= d060b7f2
LOG       ?= sim.log
FILELIST  ?= bw_mult.f
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and search $(LOG) for the fail message"
	@echo "  clean  remove the build directory and the log"
	@echo "variables:"
	@echo "  TOP=$(TOP) SEED=$(SEED) LOG=$(LOG)"
	@echo "  FILELIST=$(FILELIST) OBJ_DIR=$(OBJ_DIR) VERILATOR=$(VERILATOR)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=32\'h$(SEED) \
		-f $(FILELIST) --Mdir $(OBJ_DIR)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "ERRORS FOUND" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bw_cpa.sv */
// bw_cpa module, ripple carry-propagate adder, inverted sign carry and output register
`timescale 1ns/1ps
`include "bw_mult_settings.svh"

module bw_cpa
   import bw_mult_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      stage1_valid,
   input  csa_row_t  carry_row,
   input  csa_row_t  sum_row,
   input  low_bits_t low_bits,
   output product_t  product,
   output logic      out_valid
);

   // Column k has weight Y+k. It adds carry bit k of the last array row to
   // sum bit k+1, since the sum row sits one column higher.
   logic [`BW_X_WIDTH-2:0] upper_sum;   // product bits Y to P-2
   logic [`BW_X_WIDTH-2:0] ripple;      // carry out of each column
   logic [`BW_X_WIDTH-2:0] prop;
   product_t               next_product;

   for (genvar k = 0; k < `BW_X_WIDTH - 1; k++) begin : g_col

      assign prop[k] = carry_row[k] ^ sum_row[k+1];

      if (k == 0) begin : g_ha
         assign upper_sum[k] = prop[k];
         assign ripple[k]    = carry_row[k] & sum_row[k+1];
      end else begin : g_fa
         assign upper_sum[k] = prop[k] ^ ripple[k-1];
         assign ripple[k]    = (carry_row[k] & sum_row[k+1]) | (ripple[k-1] & prop[k]);
      end

   end

   // inverting the last carry adds the Baugh-Wooley one at weight P-1
   assign next_product = {~ripple[`BW_X_WIDTH-2], upper_sum, low_bits};

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
         product   <= '0;
      end else begin
         out_valid <= stage1_valid;
         if (stage1_valid) begin
            product <= next_product;   // holds the last result between valid strobes
         end
      end
   end

endmodule

/* bw_csa_array.sv */
// bw_csa_array module, carry-save reduction rows with correction ones and stage-1 register
`timescale 1ns/1ps
`include "bw_mult_settings.svh"

module bw_csa_array
   import bw_mult_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       in_valid,
   input  pp_matrix_t pp,
   output csa_row_t   carry_row,
   output csa_row_t   sum_row,
   output low_bits_t  low_bits,
   output logic       stage1_valid
);

   // sum_w[i][j] carries weight i+j and carry_w[i][j] weight i+j+1. The top
   // bit of each row enters the array unchanged as sum bit X-1, and so there
   // is never a carry out of that column.
   csa_row_t  sum_w   [1:`BW_Y_WIDTH-1];
   csa_row_t  carry_w [1:`BW_Y_WIDTH-1];
   low_bits_t low_w;

   assign low_w[0] = pp[0][0];   // weight 0 needs no addition

   for (genvar i = 1; i < `BW_Y_WIDTH; i++) begin : g_row

      assign sum_w[i][`BW_X_WIDTH-1]   = pp[i][`BW_X_WIDTH-1];
      assign carry_w[i][`BW_X_WIDTH-1] = 1'b0;

      for (genvar j = 0; j < `BW_X_WIDTH - 1; j++) begin : g_cell

         if (i == 1) begin : g_first
            // the first row adds pp rows 0 and 1 and puts the correction ones
            // at weights X-1 and Y-1, which are columns X-2 and Y-2 here
            if (j == `BW_X_WIDTH - 2 || j == `BW_Y_WIDTH - 2) begin : g_fa_one
               assign sum_w[i][j]   = ~(pp[1][j] ^ pp[0][j+1]);   // full adder with cin of 1
               assign carry_w[i][j] = pp[1][j] | pp[0][j+1];
            end else begin : g_ha
               assign sum_w[i][j]   = pp[1][j] ^ pp[0][j+1];
               assign carry_w[i][j] = pp[1][j] & pp[0][j+1];
            end
         end else begin : g_fa
            logic a;
            logic b;
            logic c;

            assign a = pp[i][j];
            assign b = sum_w[i-1][j+1];   // sum of the row above, shifted down one column
            assign c = carry_w[i-1][j];

            assign sum_w[i][j]   = a ^ b ^ c;
            assign carry_w[i][j] = (a & b) | (c & (a ^ b));
         end

      end

      assign low_w[i] = sum_w[i][0];   // lowest sum bit of each row is final

   end

   always_ff @(posedge clk) begin
      if (reset) begin
         stage1_valid <= 1'b0;
      end else begin
         stage1_valid <= in_valid;
      end
   end

   // payload holds its value while no operand pair is presented
   always_ff @(posedge clk) begin
      if (in_valid) begin
         carry_row <= carry_w[`BW_Y_WIDTH-1];
         sum_row   <= sum_w[`BW_Y_WIDTH-1];
         low_bits  <= low_w;
      end
   end

endmodule

/* bw_mult.f */
+incdir+.
bw_mult_pkg.sv
bw_pp_gen.sv
bw_csa_array.sv
bw_cpa.sv
bw_mult.sv
bw_mult_tb.sv

/* bw_mult.sv */
// bw_mult module, top level of the two-stage pipelined Baugh-Wooley multiplier
`timescale 1ns/1ps
`include "bw_mult_settings.svh"

module bw_mult
   import bw_mult_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       in_valid,
   input  x_operand_t x,
   input  y_operand_t y,
   output product_t   product,
   output logic       out_valid
);

   pp_matrix_t pp;
   csa_row_t   carry_row;
   csa_row_t   sum_row;
   low_bits_t  low_bits;
   logic       stage1_valid;

   bw_pp_gen u_pp_gen (
      .x  (x),
      .y  (y),
      .pp (pp)
   );

   // stage 1 registers the rows left at the bottom of the array
   bw_csa_array u_csa_array (
      .clk          (clk),
      .reset        (reset),
      .in_valid     (in_valid),
      .pp           (pp),
      .carry_row    (carry_row),
      .sum_row      (sum_row),
      .low_bits     (low_bits),
      .stage1_valid (stage1_valid)
   );

   // stage 2 registers the finished product
   bw_cpa u_cpa (
      .clk          (clk),
      .reset        (reset),
      .stage1_valid (stage1_valid),
      .carry_row    (carry_row),
      .sum_row      (sum_row),
      .low_bits     (low_bits),
      .product      (product),
      .out_valid    (out_valid)
   );

endmodule

/* bw_mult_pkg.sv */
// vector types for operands, partial-product rows and matrix, array rows and product
`include "bw_mult_settings.svh"

package bw_mult_pkg;

   // operands as presented at the top level
   typedef logic signed [`BW_X_WIDTH-1:0] x_operand_t;
   typedef logic signed [`BW_Y_WIDTH-1:0] y_operand_t;

   // row i holds x & y[i] with the Baugh-Wooley inversions applied
   typedef logic [`BW_X_WIDTH-1:0] pp_row_t;

   typedef pp_row_t [`BW_Y_WIDTH-1:0] pp_matrix_t;   // row index is the multiplier bit

   typedef logic [`BW_X_WIDTH-1:0] csa_row_t;   // carry or sum row of the array

   typedef logic [`BW_Y_WIDTH-1:0] low_bits_t;   // one product bit retired per row

   typedef logic signed [`BW_P_WIDTH-1:0] product_t;

endpackage

/* bw_mult_settings.svh */
// operand, multiplier and product width macros for the Baugh-Wooley multiplier
`ifndef BW_MULT_SETTINGS_SVH
`define BW_MULT_SETTINGS_SVH

// Both operands are two's complement. The multiplicand width sets the
// width of every partial-product row and of the carry-save rows. The
// multiplier width sets how many rows the array has.
`define BW_X_WIDTH 16   // multiplicand, one column per bit

`define BW_Y_WIDTH 12   // multiplier, one partial-product row per bit

// a signed product never needs more than the sum of the operand widths
`define BW_P_WIDTH (`BW_X_WIDTH + `BW_Y_WIDTH)

`endif

/* bw_mult_tb_model.svh */
// signed product reference model, random operand helpers and the expected result queue
`ifndef BW_MULT_TB_MODEL_SVH
`define BW_MULT_TB_MODEL_SVH

logic [`BW_P_WIDTH-1:0] expected_q [$];   // oldest accepted operand pair at the front

// both operands are sign-extended to 64 bits before the multiply
function automatic logic [`BW_P_WIDTH-1:0] signed_product(
   input logic [`BW_X_WIDTH-1:0] a,
   input logic [`BW_Y_WIDTH-1:0] b
);
   logic signed [63:0] a_ext;
   logic signed [63:0] b_ext;
   logic signed [63:0] full;
   a_ext = {{(64 - `BW_X_WIDTH){a[`BW_X_WIDTH-1]}}, a};
   b_ext = {{(64 - `BW_Y_WIDTH){b[`BW_Y_WIDTH-1]}}, b};
   full  = a_ext * b_ext;
   return full[`BW_P_WIDTH-1:0];   // a 16 by 12 product always fits in 28 bits
endfunction

function automatic void record_operands(
   input logic [`BW_X_WIDTH-1:0] a,
   input logic [`BW_Y_WIDTH-1:0] b
);
   expected_q.push_back(signed_product(a, b));
endfunction

function automatic logic [`BW_X_WIDTH-1:0] random_multiplicand();
   logic [31:0] r;
   r = $urandom();
   return r[`BW_X_WIDTH-1:0];
endfunction

function automatic logic [`BW_Y_WIDTH-1:0] random_multiplier();
   logic [31:0] r;
   r = $urandom();
   return r[`BW_Y_WIDTH-1:0];
endfunction

`endif

/* bw_mult_tb.sv */
// bw_mult_tb module, clock, reset, random stimulus, scoreboard, watchdog and summary
`timescale 1ns/1ps
`include "bw_mult_settings.svh"

module bw_mult_tb
   import bw_mult_pkg::*;
#(
   parameter logic [31:0] SEED = 32'hd060b7f2
);

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 4;
   localparam int IDLE_CHECK   = 6;
   localparam int NUM_CORNER   = 6;
   localparam int NUM_B2B      = 200;
   localparam int NUM_GAPPED   = 150;
   localparam int MAX_GAP      = 3;
   localparam int NUM_PER_SIGN = 40;
   localparam int DRAIN_LIMIT  = 8;
   localparam int NUM_TESTS    = 5;
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + IDLE_CHECK + NUM_CORNER + NUM_B2B
                                  + NUM_GAPPED * (MAX_GAP + 1) + 4 * NUM_PER_SIGN
                                  + NUM_TESTS * (DRAIN_LIMIT + 2) + 50;

   logic       clk;
   logic       reset;
   logic       in_valid;
   x_operand_t x;
   y_operand_t y;
   product_t   product;
   logic       out_valid;

   int error_count;
   int results_seen;
   int tests_passed;
   int tests_failed;
   int test_errors_start;
   int test_results_start;

   `include "bw_mult_tb_model.svh"

   bw_mult dut0 (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .x         (x),
      .y         (y),
      .product   (product),
      .out_valid (out_valid)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // inputs are sampled at the rising edge and outputs are checked at the falling edge
   initial begin : scoreboard
      logic [`BW_P_WIDTH-1:0] expected;
      logic [`BW_P_WIDTH-1:0] last_product;
      logic                   valid_d1;
      logic                   valid_d2;
      last_product = '0;
      valid_d1     = 1'b0;
      valid_d2     = 1'b0;
      forever begin
         @(posedge clk);
         if (reset) begin
            valid_d1     = 1'b0;
            valid_d2     = 1'b0;
            last_product = '0;   // product clears in reset
         end else begin
            valid_d2 = valid_d1;
            valid_d1 = in_valid;
            if (in_valid) begin
               record_operands(x, y);
            end
         end
         @(negedge clk);
         if (out_valid !== valid_d2) begin
            $display("MISMATCH out_valid expected %h actual %h", valid_d2, out_valid);
            error_count++;
         end
         if (out_valid === 1'b1) begin
            if (expected_q.size() == 0) begin
               $display("a result was presented with no operand pair waiting for it");
               error_count++;
            end else begin
               expected = expected_q.pop_front();
               results_seen++;
               if (product !== expected) begin
                  $display("MISMATCH product expected %h actual %h", expected, product);
                  error_count++;
               end
               last_product = expected;
            end
         end else if (product !== last_product) begin   // must hold between results
            $display("MISMATCH product expected %h actual %h", last_product, product);
            error_count++;
         end
      end
   end

   task automatic drive_pair(input logic [`BW_X_WIDTH-1:0] a,
                             input logic [`BW_Y_WIDTH-1:0] b);
      @(negedge clk);
      in_valid = 1'b1;
      x        = a;
      y        = b;
   endtask

   // operands keep changing while idle and the product must not follow them
   task automatic drive_idle(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         in_valid = 1'b0;
         x        = random_multiplicand();
         y        = random_multiplier();
      end
   endtask

   task automatic drain_pipeline();
      int waited;
      waited = 0;
      @(negedge clk);
      in_valid = 1'b0;
      while (expected_q.size() != 0 && waited < DRAIN_LIMIT) begin
         @(posedge clk);
         waited++;
      end
      if (expected_q.size() != 0) begin
         $display("%0d results never appeared at the output", expected_q.size());
         error_count++;
      end
      @(posedge clk);
   endtask

   task automatic start_test();
      test_errors_start  = error_count;
      test_results_start = results_seen;
   endtask

   task automatic finish_test(input string name);
      int errors;
      drain_pipeline();
      errors = error_count - test_errors_start;
      if (errors == 0) begin
         tests_passed++;
      end else begin
         tests_failed++;
      end
      $display("test %s: %s, %0d results, %0d errors", name, (errors == 0) ? "pass" : "fail",
               results_seen - test_results_start, errors);
   endtask

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout, the run did not end within %0d clock cycles", WATCHDOG_CYCLES);
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin : stimulus
      logic [`BW_X_WIDTH-1:0] a;
      logic [`BW_Y_WIDTH-1:0] b;
      int                     gap;
      reset        = 1'b1;
      in_valid     = 1'b0;
      x            = '0;
      y            = '0;
      error_count  = 0;
      results_seen = 0;
      tests_passed = 0;
      tests_failed = 0;
      void'($urandom(SEED));
      start_test();
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;

      if (out_valid !== 1'b0) begin
         $display("MISMATCH out_valid expected %h actual %h", 1'b0, out_valid);
         error_count++;
      end
      if (product !== '0) begin
         $display("MISMATCH product expected %h actual %h", {`BW_P_WIDTH{1'b0}}, product);
         error_count++;
      end
      drive_idle(IDLE_CHECK);
      drive_pair(random_multiplicand(), random_multiplier());
      finish_test("reset state");

      start_test();
      drive_pair(16'h8000, 12'h800);
      drive_pair(16'h8000, 12'hfff);
      drive_pair(16'h7fff, 12'h7ff);
      drive_pair('0, random_multiplier());
      drive_pair(random_multiplicand(), '0);
      drive_pair(16'hffff, 12'hfff);
      finish_test("corner operands");

      start_test();
      repeat (NUM_B2B) drive_pair(random_multiplicand(), random_multiplier());
      finish_test("back-to-back products");

      start_test();
      repeat (NUM_GAPPED) begin
         drive_pair(random_multiplicand(), random_multiplier());
         gap = $urandom % (MAX_GAP + 1);
         drive_idle(gap);
      end
      finish_test("gapped stimulus");

      start_test();
      for (int s = 0; s < 4; s++) begin
         repeat (NUM_PER_SIGN) begin
            a = random_multiplicand();
            b = random_multiplier();
            a[`BW_X_WIDTH-1] = s[1];   // force the sign combination
            b[`BW_Y_WIDTH-1] = s[0];
            drive_pair(a, b);
         end
      end
      finish_test("sign-bit coverage");

      if (expected_q.size() != 0) begin
         $display("%0d expected results left over at the end", expected_q.size());
         error_count++;
      end
      $display("tests passed %0d, failed %0d, results checked %0d, errors %0d",
               tests_passed, tests_failed, results_seen, error_count);
      if (error_count == 0 && tests_failed == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

/* bw_pp_gen.sv */
// bw_pp_gen module, Baugh-Wooley partial-product matrix with sign-bit inversion
`timescale 1ns/1ps
`include "bw_mult_settings.svh"

module bw_pp_gen
   import bw_mult_pkg::*;
(
   input  x_operand_t x,
   input  y_operand_t y,
   output pp_matrix_t pp
);

   // Marks every bit that pairs exactly one sign bit with a magnitude bit.
   // The sign-by-sign bit pairs two sign bits and so stays clear.
   function automatic pp_matrix_t sign_mask();
      pp_matrix_t mask;
      mask = '0;
      for (int i = 0; i < `BW_Y_WIDTH - 1; i++) begin
         mask[i][`BW_X_WIDTH-1] = 1'b1;   // x sign against a magnitude bit of y
      end
      mask[`BW_Y_WIDTH-1][`BW_X_WIDTH-2:0] = '1;   // y sign against magnitude bits of x
      return mask;
   endfunction

   localparam pp_matrix_t SIGN_MASK = sign_mask();

   pp_matrix_t and_terms;

   for (genvar i = 0; i < `BW_Y_WIDTH; i++) begin : g_row
      assign and_terms[i] = x & {`BW_X_WIDTH{y[i]}};   // one row per multiplier bit
   end

   assign pp = and_terms ^ SIGN_MASK;   // xor with a set mask bit turns the and into a nand

endmodule
